// ==== rtl/cpuPkg.sv ====
package cpuPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] regAddr_t;

    localparam word_t resetPc = 32'h0000_0000;
    localparam word_t pcStep = 32'd4;
    localparam int regCount = 32;

    // Primary opcode field
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opAddiu   = 6'h09,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcode_t;

    // Function field of special opcode
    typedef enum logic [5:0] {
        fnJr   = 6'h08,
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnSlt  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluLui
    } aluOp_t;

    typedef enum logic [2:0] {
        brNone,
        brBeq,
        brBne,
        brJump,
        brJumpReg
    } branchKind_t;

    typedef enum logic [1:0] {
        wbNone,
        wbAlu,
        wbMem
    } wbSel_t;

    typedef struct packed {
        aluOp_t aluOp;
        logic useImm;
        logic zeroExtend;
        word_t imm;
        regAddr_t rs;
        logic rsUsed;
        regAddr_t rt;
        logic rtUsed;
        regAddr_t dest;
        logic regWrite;
        wbSel_t wbSel;
        logic memRead;
        logic memWrite;
        branchKind_t branchKind;
    } ctrlWord_t;

    // One in-flight result offered to decode
    typedef struct packed {
        logic regWrite;
        regAddr_t dest;
        logic ready;
        word_t value;
    } forwardSrc_t;

    typedef struct packed {
        logic readEn;
        word_t addr;
    } instReq_t;

    typedef struct packed {
        logic read;
        logic write;
        word_t addr;
        word_t wdata;
    } memReq_t;

    typedef struct packed {
        word_t pc;
        logic wen;
        regAddr_t wnum;
        word_t wdata;
    } wbTrace_t;

endpackage

// ==== rtl/fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit import cpuPkg::*; (
    input logic clk,
    input logic reset,
    input logic stall,
    input logic redirect,
    input word_t target,
    output instReq_t instReq,
    input logic instSramValid,
    output logic accepted,
    output word_t pc
);

    word_t fetchPc;
    word_t nextPc;
    logic pendingValid;
    word_t pendingTarget;

    // Fetch always requests and moves only on acceptance
    assign instReq.readEn = 1'b1;
    assign instReq.addr = fetchPc;
    assign pc = fetchPc;
    assign accepted = instSramValid && !stall;

    // Redirect takes effect once the delay slot is accepted
    always_comb begin
        if (redirect) begin
            nextPc = target;
        end else if (pendingValid) begin
            nextPc = pendingTarget;
        end else begin
            nextPc = fetchPc + pcStep;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetchPc <= resetPc;
            pendingValid <= 1'b0;
        end else if (accepted) begin
            fetchPc <= nextPc;
            pendingValid <= 1'b0;
        end else if (redirect) begin
            pendingValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect && !accepted) begin
            pendingTarget <= target;
        end
    end

endmodule

// ==== rtl/instDecoder.sv ====
`timescale 1ns/1ps

module instDecoder import cpuPkg::*; (
    input word_t instruction,
    output ctrlWord_t ctrl
);

    opcode_t opcode;
    funct_t funct;
    logic [15:0] imm16;
    logic aluRtype;

    assign opcode = opcode_t'(instruction[31:26]);
    assign funct = funct_t'(instruction[5:0]);
    assign imm16 = instruction[15:0];

    always_comb begin
        ctrl = '0;
        aluRtype = 1'b0;
        ctrl.rs = instruction[25:21];
        ctrl.rt = instruction[20:16];
        case (opcode)
            opSpecial: begin
                aluRtype = 1'b1;
                case (funct)
                    fnAddu: ctrl.aluOp = aluAdd;
                    fnSubu: ctrl.aluOp = aluSub;
                    fnAnd: ctrl.aluOp = aluAnd;
                    fnOr: ctrl.aluOp = aluOr;
                    fnSlt: ctrl.aluOp = aluSlt;
                    fnJr: begin
                        aluRtype = 1'b0;
                        ctrl.rsUsed = 1'b1;
                        ctrl.branchKind = brJumpReg;
                    end
                    default: aluRtype = 1'b0;
                endcase
            end
            opAddiu, opOri, opLui, opLw: begin
                ctrl.useImm = 1'b1;
                ctrl.rsUsed = (opcode != opLui);
                ctrl.dest = instruction[20:16];
                ctrl.regWrite = 1'b1;
                ctrl.memRead = (opcode == opLw);
                ctrl.wbSel = (opcode == opLw) ? wbMem : wbAlu;
                ctrl.zeroExtend = (opcode == opOri) || (opcode == opLui);
                ctrl.aluOp = (opcode == opOri) ? aluOr : (opcode == opLui) ? aluLui : aluAdd;
            end
            opSw: begin
                ctrl.useImm = 1'b1;
                ctrl.rsUsed = 1'b1;
                ctrl.rtUsed = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            opBeq, opBne: begin
                ctrl.rsUsed = 1'b1;
                ctrl.rtUsed = 1'b1;
                ctrl.branchKind = (opcode == opBeq) ? brBeq : brBne;
            end
            opJ: ctrl.branchKind = brJump;
            default: ;
        endcase
        if (aluRtype) begin
            ctrl.rsUsed = 1'b1;
            ctrl.rtUsed = 1'b1;
            ctrl.dest = instruction[15:11];
            ctrl.regWrite = 1'b1;
            ctrl.wbSel = wbAlu;
        end
        ctrl.imm = ctrl.zeroExtend ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};
        // Writes to $zero are dropped here so later stages never see them
        if (ctrl.dest == '0) begin
            ctrl.regWrite = 1'b0;
            ctrl.wbSel = wbNone;
        end
    end

endmodule

// ==== rtl/registerFile.sv ====
`timescale 1ns/1ps

module registerFile import cpuPkg::*; (
    input logic clk,
    input logic reset,
    input regAddr_t readAddr [2],
    output word_t readData [2],
    input logic writeEn,
    input regAddr_t writeAddr,
    input word_t writeData
);

    word_t regs [regCount];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // $zero is cleared on reset and never written
    assign readData[0] = regs[readAddr[0]];
    assign readData[1] = regs[readAddr[1]];

endmodule

// ==== rtl/operandForward.sv ====
`timescale 1ns/1ps

module operandForward import cpuPkg::*; (
    input logic enabled,
    input regAddr_t request,
    input word_t original,
    input forwardSrc_t sources [3],
    output word_t value,
    output logic waiting
);

    logic matched;

    // Sources come newest first, so the first hit wins
    always_comb begin
        value = original;
        waiting = 1'b0;
        matched = 1'b0;
        for (int i = 0; i < 3; i++) begin
            if (!matched && sources[i].regWrite && request != '0 &&
                    sources[i].dest == request) begin
                matched = 1'b1;
                value = sources[i].value;
                waiting = enabled && !sources[i].ready;
            end
        end
    end

endmodule

// ==== rtl/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage import cpuPkg::*; (
    input logic clk,
    input logic reset,
    input logic valid,
    input word_t instruction,
    input word_t pc,
    input forwardSrc_t sources [3],
    input logic writeEn,
    input regAddr_t writeAddr,
    input word_t writeData,
    output ctrlWord_t ctrl,
    output word_t operands [2],
    output logic hazard,
    output logic redirect,
    output word_t target
);

    regAddr_t srcReg [2];
    logic srcUsed [2];
    word_t rfData [2];
    logic waiting [2];
    word_t seqPc;
    logic taken;

    instDecoder uDecoder (.instruction(instruction), .ctrl(ctrl));

    assign srcReg[0] = ctrl.rs;
    assign srcReg[1] = ctrl.rt;
    assign srcUsed[0] = valid && ctrl.rsUsed;
    assign srcUsed[1] = valid && ctrl.rtUsed;

    registerFile uRegs (
        .clk(clk),
        .reset(reset),
        .readAddr(srcReg),
        .readData(rfData),
        .writeEn(writeEn),
        .writeAddr(writeAddr),
        .writeData(writeData)
    );

    for (genvar g = 0; g < 2; g++) begin : gForward
        operandForward uFwd (
            .enabled(srcUsed[g]),
            .request(srcReg[g]),
            .original(rfData[g]),
            .sources(sources),
            .value(operands[g]),
            .waiting(waiting[g])
        );
    end

    assign hazard = waiting[0] || waiting[1];
    assign seqPc = pc + pcStep;

    always_comb begin
        taken = 1'b0;
        target = seqPc + {ctrl.imm[29:0], 2'b00};
        case (ctrl.branchKind)
            brBeq: taken = (operands[0] == operands[1]);
            brBne: taken = (operands[0] != operands[1]);
            brJump: begin
                taken = 1'b1;
                target = {seqPc[31:28], instruction[25:0], 2'b00};
            end
            brJumpReg: begin
                taken = 1'b1;
                target = operands[0];
            end
            default: ;
        endcase
    end

    assign redirect = valid && !hazard && taken;

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu import cpuPkg::*; (
    input aluOp_t op,
    input word_t a,
    input word_t b,
    output word_t result
);

    always_comb begin
        case (op)
            aluAdd: result = a + b;
            aluSub: result = a - b;
            aluAnd: result = a & b;
            aluOr: result = a | b;
            aluSlt: result = {31'b0, $signed(a) < $signed(b)};
            // Immediate arrives zero extended in the low half
            aluLui: result = {b[15:0], 16'b0};
            default: result = '0;
        endcase
    end

endmodule

// ==== rtl/mipsCore.sv ====
`timescale 1ns/1ps

module mipsCore import cpuPkg::*; (
    input logic clk,
    input logic reset,
    output instReq_t instReq,
    input word_t instSramRdata,
    input logic instSramValid,
    output memReq_t memReq,
    input word_t dataSramRdata,
    input logic dataSramValid,
    output wbTrace_t wbTrace
);

    logic memWait;
    logic hazard;
    logic fetchStall;
    logic accepted;
    logic redirect;
    word_t target;
    word_t fetchPc;
    forwardSrc_t fwdSources [3];

    logic dValid;
    word_t dInst;
    word_t dPc;
    ctrlWord_t dCtrl;
    word_t dOperands [2];

    logic eValid;
    ctrlWord_t eCtrl;
    word_t ePc;
    word_t eOperands [2];
    word_t aluB;
    word_t aluResult;

    logic mValid;
    ctrlWord_t mCtrl;
    word_t mPc;
    word_t mAlu;
    word_t mStoreData;

    logic wValid;
    ctrlWord_t wCtrl;
    word_t wPc;
    word_t wAlu;
    word_t wMem;
    word_t wbData;

    // Memory wait freezes everything up to memory stage
    assign memWait = mValid && (mCtrl.memRead || mCtrl.memWrite) && !dataSramValid;
    assign fetchStall = memWait || hazard;

    fetchUnit uFetch (
        .clk(clk),
        .reset(reset),
        .stall(fetchStall),
        .redirect(redirect),
        .target(target),
        .instReq(instReq),
        .instSramValid(instSramValid),
        .accepted(accepted),
        .pc(fetchPc)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            dValid <= 1'b0;
        end else if (!fetchStall) begin
            dValid <= accepted;
        end
    end

    always_ff @(posedge clk) begin
        if (!fetchStall) begin
            dInst <= instSramRdata;
            dPc <= fetchPc;
        end
    end

    // Sources ordered newest first from execute to writeback
    assign fwdSources[0] = '{regWrite: eValid && eCtrl.regWrite, dest: eCtrl.dest,
                             ready: !eCtrl.memRead, value: aluResult};
    assign fwdSources[1] = '{regWrite: mValid && mCtrl.regWrite, dest: mCtrl.dest,
                             ready: !mCtrl.memRead, value: mAlu};
    assign fwdSources[2] = '{regWrite: wbTrace.wen, dest: wbTrace.wnum,
                             ready: 1'b1, value: wbData};

    decodeStage uDecode (
        .clk(clk),
        .reset(reset),
        .valid(dValid),
        .instruction(dInst),
        .pc(dPc),
        .sources(fwdSources),
        .writeEn(wbTrace.wen),
        .writeAddr(wbTrace.wnum),
        .writeData(wbTrace.wdata),
        .ctrl(dCtrl),
        .operands(dOperands),
        .hazard(hazard),
        .redirect(redirect),
        .target(target)
    );

    // Hazard leaves a bubble in execute
    always_ff @(posedge clk) begin
        if (reset) begin
            eValid <= 1'b0;
        end else if (!memWait) begin
            eValid <= dValid && !hazard;
        end
    end

    always_ff @(posedge clk) begin
        if (!memWait) begin
            eCtrl <= dCtrl;
            ePc <= dPc;
            eOperands <= dOperands;
        end
    end

    assign aluB = eCtrl.useImm ? eCtrl.imm : eOperands[1];

    alu uAlu (.op(eCtrl.aluOp), .a(eOperands[0]), .b(aluB), .result(aluResult));

    always_ff @(posedge clk) begin
        if (reset) begin
            mValid <= 1'b0;
        end else if (!memWait) begin
            mValid <= eValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!memWait) begin
            mCtrl <= eCtrl;
            mPc <= ePc;
            mAlu <= aluResult;
            mStoreData <= eOperands[1];
        end
    end

    assign memReq.read = mValid && mCtrl.memRead;
    assign memReq.write = mValid && mCtrl.memWrite;
    assign memReq.addr = mAlu;
    assign memReq.wdata = mStoreData;

    always_ff @(posedge clk) begin
        if (reset) begin
            wValid <= 1'b0;
        end else begin
            wValid <= mValid && !memWait;
        end
    end

    always_ff @(posedge clk) begin
        wCtrl <= mCtrl;
        wPc <= mPc;
        wAlu <= mAlu;
        wMem <= dataSramRdata;
    end

    assign wbData = (wCtrl.wbSel == wbMem) ? wMem : wAlu;

    assign wbTrace.pc = wPc;
    assign wbTrace.wen = wValid && wCtrl.regWrite;
    assign wbTrace.wnum = wCtrl.dest;
    assign wbTrace.wdata = wbData;

endmodule

// ==== bench/mipsCore_assert.sv ====
`timescale 1ns/1ps

module mipsCore_assert import cpuPkg::*; (
    input logic clk,
    input logic reset,
    input instReq_t instReq,
    input logic instSramValid,
    input memReq_t memReq,
    input logic dataSramValid,
    input wbTrace_t wbTrace
);

    memExclusive: assert property (@(posedge clk) disable iff (reset)
        !(memReq.read && memReq.write))
        else $error("data request has read and write high together");

    // Request frozen until the SRAM answers
    memHeld: assert property (@(posedge clk) disable iff (reset)
        (memReq.read || memReq.write) && !dataSramValid |=> $stable(memReq))
        else $error("data request changed while waiting for valid");

    fetchHeld: assert property (@(posedge clk) disable iff (reset)
        instReq.readEn && !instSramValid |=> $stable(instReq.addr))
        else $error("fetch address changed while waiting for valid");

    noZeroWrite: assert property (@(posedge clk) disable iff (reset)
        wbTrace.wen |-> wbTrace.wnum != '0)
        else $error("writeback reported a write to register zero");

endmodule

// ==== bench/mipsCoreTb.sv ====
`timescale 1ns/1ps

module mipsCoreTb import cpuPkg::*; ();

    localparam int progLen = 50;
    localparam int memWords = 256;
    localparam int cycleLimit = progLen * 24 + 40;
    localparam word_t dataPattern = 32'h5a5a0000;

    typedef struct packed {
        word_t inst;
        logic write;
        regAddr_t num;
        word_t value;
        logic [2:0] group;
    } progEntry_t;

    logic clk;
    logic reset;
    instReq_t instReq;
    word_t instSramRdata;
    logic instSramValid;
    memReq_t memReq;
    word_t dataSramRdata;
    logic dataSramValid;
    wbTrace_t wbTrace;

    progEntry_t progTable [progLen];
    word_t instMem [memWords];
    word_t dataMem [memWords];
    int expected [$];
    string testNames [5] = '{"reset", "alu ops", "load store", "dependency chain",
                             "branch and jump"};
    logic [31:0] lcgState = 32'h2838_1b27;
    int instGap;
    int dataGap;
    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int groupStart = 0;
    int nextWrite = 0;
    int idx;

    mipsCore dut (
        .clk(clk),
        .reset(reset),
        .instReq(instReq),
        .instSramRdata(instSramRdata),
        .instSramValid(instSramValid),
        .memReq(memReq),
        .dataSramRdata(dataSramRdata),
        .dataSramValid(dataSramValid),
        .wbTrace(wbTrace)
    );

    bind mipsCore mipsCore_assert uAssert (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [1:0] randomDelay();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[17:16];
    endfunction

    function automatic word_t rType(funct_t fn, regAddr_t rs, regAddr_t rt, regAddr_t rd);
        return {opSpecial, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t iType(opcode_t op, regAddr_t rs, regAddr_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic progEntry_t entry(word_t inst, logic wr, regAddr_t num, word_t val,
                                         logic [2:0] grp);
        return '{inst: inst, write: wr, num: num, value: val, group: grp};
    endfunction

    task automatic checkValue(string name, word_t got, word_t want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("CHECK FAILED: %s got %h expected %h", name, got, want);
        end
    endtask

    // Combinational SRAM reads answering in the same cycle
    assign instSramRdata = instMem[instReq.addr[9:2]];
    assign dataSramRdata = dataMem[memReq.addr[9:2]];

    always @(posedge clk) begin
        if (!reset && memReq.write && dataSramValid) begin
            dataMem[memReq.addr[9:2]] <= memReq.wdata;
        end
    end

    // After each high beat a fresh gap of 0 to 3 low cycles
    always @(posedge clk) begin
        int gap;
        if (reset) begin
            instSramValid <= 1'b0;
            dataSramValid <= 1'b0;
            instGap <= 0;
            dataGap <= 0;
        end else begin
            if (instSramValid) begin
                gap = randomDelay();
                instSramValid <= (gap == 0);
                instGap <= (gap == 0) ? 0 : gap - 1;
            end else if (instGap == 0) begin
                instSramValid <= 1'b1;
            end else begin
                instGap <= instGap - 1;
            end
            if (dataSramValid) begin
                gap = randomDelay();
                dataSramValid <= (gap == 0);
                dataGap <= (gap == 0) ? 0 : gap - 1;
            end else if (dataGap == 0) begin
                dataSramValid <= 1'b1;
            end else begin
                dataGap <= dataGap - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout after %0d cycles, %0d of %0d writes seen",
                     cycles, nextWrite, expected.size());
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic loadProgram();
        progTable[0] = entry(iType(opAddiu, 0, 1, 16'h1234), 1, 1, 32'h0000_1234, 1);
        progTable[1] = entry(iType(opLui, 0, 2, 16'h8000), 1, 2, 32'h8000_0000, 1);
        progTable[2] = entry(iType(opOri, 0, 3, 16'hf0f0), 1, 3, 32'h0000_f0f0, 1);
        progTable[3] = entry(iType(opAddiu, 0, 4, 16'hfffb), 1, 4, 32'hffff_fffb, 1);
        progTable[4] = entry(rType(fnAddu, 1, 3, 5), 1, 5, 32'h0001_0324, 1);
        progTable[5] = entry(rType(fnSubu, 1, 3, 6), 1, 6, 32'hffff_2144, 1);
        progTable[6] = entry(rType(fnAnd, 5, 3, 7), 1, 7, 32'h0000_0020, 1);
        progTable[7] = entry(rType(fnOr, 2, 4, 8), 1, 8, 32'hffff_fffb, 1);
        progTable[8] = entry(rType(fnSlt, 4, 1, 9), 1, 9, 32'h0000_0001, 1);
        progTable[9] = entry(rType(fnSlt, 1, 2, 10), 1, 10, 32'h0000_0000, 1);
        progTable[10] = entry(iType(opAddiu, 1, 0, 16'h0005), 0, 0, 32'h0, 1);
        progTable[11] = entry(iType(opAddiu, 0, 11, 16'h0100), 1, 11, 32'h0000_0100, 2);
        progTable[12] = entry(iType(opSw, 11, 5, 16'h0000), 0, 0, 32'h0, 2);
        progTable[13] = entry(iType(opLw, 11, 12, 16'h0000), 1, 12, 32'h0001_0324, 2);
        progTable[14] = entry(rType(fnAddu, 12, 12, 13), 1, 13, 32'h0002_0648, 2);
        progTable[15] = entry(iType(opLw, 11, 14, 16'h0004), 1, 14, 32'h5a5a_0104, 2);
        progTable[16] = entry(rType(fnSubu, 14, 13, 15), 1, 15, 32'h5a57_fabc, 3);
        progTable[17] = entry(iType(opAddiu, 15, 15, 16'h0001), 1, 15, 32'h5a57_fabd, 3);
        progTable[18] = entry(rType(fnOr, 15, 13, 16), 1, 16, 32'h5a57_fefd, 3);
        progTable[19] = entry(iType(opSw, 11, 16, 16'hfffc), 0, 0, 32'h0, 3);
        progTable[20] = entry(iType(opLw, 11, 17, 16'hfffc), 1, 17, 32'h5a57_fefd, 3);
        progTable[21] = entry(iType(opLw, 11, 18, 16'h0008), 1, 18, 32'h5a5a_0108, 3);
        progTable[22] = entry(rType(fnAddu, 17, 18, 19), 1, 19, 32'hb4b2_0005, 3);
        // Taken beq over two words
        progTable[23] = entry(iType(opBeq, 1, 1, 16'd3), 0, 0, 32'h0, 4);
        progTable[24] = entry(iType(opAddiu, 0, 20, 16'h0011), 1, 20, 32'h0000_0011, 4);
        progTable[25] = entry(iType(opAddiu, 0, 20, 16'h0022), 0, 0, 32'h0, 4);
        progTable[26] = entry(iType(opAddiu, 0, 21, 16'h0033), 0, 0, 32'h0, 4);
        progTable[27] = entry(iType(opBne, 1, 1, 16'd2), 0, 0, 32'h0, 4);
        progTable[28] = entry(iType(opAddiu, 0, 21, 16'h0044), 1, 21, 32'h0000_0044, 4);
        progTable[29] = entry(iType(opAddiu, 0, 22, 16'h0055), 1, 22, 32'h0000_0055, 4);
        progTable[30] = entry(iType(opBne, 4, 1, 16'd2), 0, 0, 32'h0, 4);
        progTable[31] = entry(rType(fnAddu, 20, 21, 23), 1, 23, 32'h0000_0055, 4);
        progTable[32] = entry(iType(opAddiu, 0, 23, 16'h0066), 0, 0, 32'h0, 4);
        progTable[33] = entry(iType(opBeq, 20, 21, 16'd1), 0, 0, 32'h0, 4);
        progTable[34] = entry(iType(opAddiu, 0, 24, 16'h0077), 1, 24, 32'h0000_0077, 4);
        progTable[35] = entry(iType(opAddiu, 0, 25, 16'h0088), 1, 25, 32'h0000_0088, 4);
        progTable[36] = entry({opJ, 26'd40}, 0, 0, 32'h0, 4);
        progTable[37] = entry(iType(opLw, 11, 26, 16'h0000), 1, 26, 32'h0001_0324, 4);
        progTable[38] = entry(iType(opAddiu, 0, 26, 16'h0099), 0, 0, 32'h0, 4);
        progTable[39] = entry(iType(opAddiu, 0, 27, 16'h00aa), 0, 0, 32'h0, 4);
        progTable[40] = entry(iType(opOri, 0, 28, 16'h00b0), 1, 28, 32'h0000_00b0, 4);
        progTable[41] = entry(rType(fnJr, 28, 0, 0), 0, 0, 32'h0, 4);
        progTable[42] = entry(iType(opAddiu, 28, 29, 16'h0004), 1, 29, 32'h0000_00b4, 4);
        progTable[43] = entry(iType(opAddiu, 0, 30, 16'h00bb), 0, 0, 32'h0, 4);
        progTable[44] = entry(rType(fnAddu, 29, 26, 31), 1, 31, 32'h0001_03d8, 4);
        // Branch right behind a load
        progTable[45] = entry(iType(opLw, 11, 1, 16'h0004), 1, 1, 32'h5a5a_0104, 4);
        progTable[46] = entry(iType(opBeq, 1, 14, 16'd2), 0, 0, 32'h0, 4);
        progTable[47] = entry(iType(opAddiu, 0, 2, 16'h0001), 1, 2, 32'h0000_0001, 4);
        progTable[48] = entry(iType(opAddiu, 0, 3, 16'h0002), 0, 0, 32'h0, 4);
        progTable[49] = entry(iType(opAddiu, 3, 3, 16'h0003), 1, 3, 32'h0000_f0f3, 4);
    endtask

    initial begin
        reset = 1'b1;
        instSramValid = 1'b0;
        dataSramValid = 1'b0;
        loadProgram();
        for (int i = 0; i < memWords; i++) begin
            instMem[i] = (i < progLen) ? progTable[i].inst : 32'h0;
            dataMem[i] = word_t'(i * 4) ^ dataPattern;
        end
        for (int i = 0; i < progLen; i++) begin
            if (progTable[i].write) begin
                expected.push_back(i);
            end
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkValue("instReq.readEn", word_t'(instReq.readEn), 32'h1);
        checkValue("instReq.addr", instReq.addr, resetPc);
        checkValue("memReq.read", word_t'(memReq.read), 32'h0);
        checkValue("memReq.write", word_t'(memReq.write), 32'h0);
        checkValue("wbTrace.wen", word_t'(wbTrace.wen), 32'h0);
        $display("test 0 %s: %0d errors", testNames[0], errors);
        groupStart = errors;
        while (nextWrite < expected.size()) begin
            @(negedge clk);
            if (wbTrace.wen) begin
                idx = expected[nextWrite];
                checkValue("wbTrace.pc", wbTrace.pc, word_t'(idx * 4));
                checkValue("wbTrace.wnum", word_t'(wbTrace.wnum), word_t'(progTable[idx].num));
                checkValue("wbTrace.wdata", wbTrace.wdata, progTable[idx].value);
                nextWrite++;
                if (nextWrite == expected.size() ||
                        progTable[expected[nextWrite]].group != progTable[idx].group) begin
                    $display("test %0d %s: %0d errors", progTable[idx].group,
                             testNames[progTable[idx].group], errors - groupStart);
                    groupStart = errors;
                end
            end
        end
        // Trailing no-ops must stay silent
        repeat (16) begin
            @(negedge clk);
            checks++;
            assert (!wbTrace.wen) else begin
                errors++;
                $display("unexpected register write to r%0d from pc %h",
                         wbTrace.wnum, wbTrace.pc);
            end
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
rtl/cpuPkg.sv
rtl/fetchUnit.sv
rtl/instDecoder.sv
rtl/registerFile.sv
rtl/operandForward.sv
rtl/decodeStage.sv
rtl/alu.sv
rtl/mipsCore.sv
bench/mipsCore_assert.sv
bench/mipsCoreTb.sv

// ==== Bender.yml ====
package:
  name: mipscore

sources:
  - rtl/cpuPkg.sv
  - rtl/fetchUnit.sv
  - rtl/instDecoder.sv
  - rtl/registerFile.sv
  - rtl/operandForward.sv
  - rtl/decodeStage.sv
  - rtl/alu.sv
  - rtl/mipsCore.sv
  - target: test
    files:
      - bench/mipsCore_assert.sv
      - bench/mipsCoreTb.sv
